// File: lcd_defines.svh
`ifndef LCD_DEFINES_SVH
`define LCD_DEFINES_SVH

// clock cycles per microsecond, 10 MHz system clock
`define LCD_CLK_PER_US 10

// power-up and init sequence, in microseconds
`define LCD_POWERUP_US 500
`define LCD_INIT_STEP_US 50
`define LCD_CLEAR_US 200
`define LCD_ENTRY_US 100

// write cycle, in microseconds from the accept cycle
`define LCD_CYCLE_US 50
`define LCD_E_START_US 1
`define LCD_E_END_US 14

// characters per display line
`define LCD_LINE_LEN 16

`endif

// File: lcd_cmd_pkg.sv
package lcd_cmd_pkg;

	// one word on the LCD parallel bus
	typedef struct packed {
		logic       rs;   // register select, 1 = data
		logic       rw;   // 1 = read, never sampled here
		logic [7:0] data;
	} lcd_word_t;

	// init configuration, msb first
	typedef struct packed {
		logic lines;      // 1 = two lines
		logic font;       // 1 = 5x10 dots
		logic display_on;
		logic cursor;
		logic blink;
		logic inc_dec;    // 1 = increment address
		logic shift;      // display shift on write
	} lcd_cfg_t;

	typedef logic [7:0] lcd_opcode_t;

	// instruction bases, option bits are or-ed in
	localparam lcd_opcode_t OP_FUNC_SET  = 8'h30;
	localparam lcd_opcode_t OP_DISP_CTRL = 8'h08;
	localparam lcd_opcode_t OP_CLEAR     = 8'h01;
	localparam lcd_opcode_t OP_ENTRY     = 8'h04;
	localparam lcd_opcode_t OP_SET_DDRAM = 8'h80;

endpackage

// File: lcd_text_pkg.sv
package lcd_text_pkg;

	// one character code, ASCII-compatible in the lower half
	typedef logic [7:0] lcd_char_t;

	// column within a display line
	typedef logic [3:0] lcd_col_t;

	// display line select, 0 = top line
	typedef logic lcd_line_t;

	// blank cell
	localparam lcd_char_t CHAR_SPACE = 8'h20;

	// DDRAM start of the second line
	localparam logic [7:0] LINE1_BASE = 8'h40;

endpackage

// File: lcd_req_if.sv
interface lcd_req_if;
	import lcd_cmd_pkg::*;

	logic      req;    // level, held until accept
	lcd_word_t word;   // stable while req is high
	logic      accept; // one-cycle, word latched
	logic      done;   // one-cycle, last cycle of the write

	modport requester (
		output req,
		output word,
		input  accept,
		input  done
	);

	modport arbiter_side (
		input  req,
		input  word,
		output accept,
		output done
	);

	modport driver (
		input  req,
		input  word,
		output accept,
		output done
	);

endinterface

// File: lcd_bus_driver.sv
`include "lcd_defines.svh"

module lcd_bus_driver (
	input  logic                  clk,
	input  logic                  reset,
	input  lcd_cmd_pkg::lcd_cfg_t cfg,
	lcd_req_if.driver             bus,
	output logic                  lcd_e,
	output logic                  lcd_rs,
	output logic                  lcd_rw,
	output logic [7:0]            lcd_data,
	output logic                  lcd_ready
);
	import lcd_cmd_pkg::*;

	localparam int unsigned INIT_E_US = 10; // enable window of an init step

	localparam logic [12:0] POWERUP_LAST = 13'(`LCD_POWERUP_US * `LCD_CLK_PER_US - 1);
	localparam logic [12:0] INIT_E_CYC = 13'(INIT_E_US * `LCD_CLK_PER_US);
	localparam logic [12:0] E_START = 13'(`LCD_E_START_US * `LCD_CLK_PER_US);
	localparam logic [12:0] E_END = 13'(`LCD_E_END_US * `LCD_CLK_PER_US);
	localparam logic [12:0] CYCLE_LAST = 13'(`LCD_CYCLE_US * `LCD_CLK_PER_US - 1);

	typedef enum logic [1:0] {POWERUP, INIT, IDLE, WRITE} state_t;

	state_t      state;
	logic [1:0]  step;      // init instruction index
	logic [12:0] cnt;       // cycles within the current phase
	lcd_word_t   word_q;    // word being written
	logic [7:0]  init_data;
	logic [12:0] step_last; // last cycle of the current init step

	// init instruction and step length from cfg
	always_comb begin
		case (step)
			2'd0: begin
				init_data = OP_FUNC_SET | {4'b0000, cfg.lines, cfg.font, 2'b00};
				step_last = 13'((INIT_E_US + `LCD_INIT_STEP_US) * `LCD_CLK_PER_US - 1);
			end
			2'd1: begin
				init_data = OP_DISP_CTRL | {5'b00000, cfg.display_on, cfg.cursor, cfg.blink};
				step_last = 13'((INIT_E_US + `LCD_INIT_STEP_US) * `LCD_CLK_PER_US - 1);
			end
			2'd2: begin
				init_data = OP_CLEAR;
				step_last = 13'((INIT_E_US + `LCD_CLEAR_US) * `LCD_CLK_PER_US - 1);
			end
			default: begin
				init_data = OP_ENTRY | {6'b000000, cfg.inc_dec, cfg.shift};
				step_last = 13'((INIT_E_US + `LCD_ENTRY_US) * `LCD_CLK_PER_US - 1);
			end
		endcase
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			state <= POWERUP;
			step <= 2'd0;
			cnt <= '0;
		end else begin
			case (state)
				POWERUP: begin
					if (cnt == POWERUP_LAST) begin
						state <= INIT;
						cnt <= '0;
					end else begin
						cnt <= cnt + 13'd1;
					end
				end
				INIT: begin
					if (cnt == step_last) begin
						cnt <= '0;
						step <= step + 2'd1; // wraps after entry mode
						if (step == 2'd3) begin
							state <= IDLE;
						end
					end else begin
						cnt <= cnt + 13'd1;
					end
				end
				IDLE: begin
					if (bus.req) begin
						state <= WRITE;
						cnt <= 13'd1; // accept cycle counts as cycle 0
					end
				end
				default: begin
					if (cnt == CYCLE_LAST) begin
						state <= IDLE;
						cnt <= '0;
					end else begin
						cnt <= cnt + 13'd1;
					end
				end
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (bus.accept) begin
			word_q <= bus.word;
		end
	end

	assign bus.accept = (state == IDLE) && bus.req;
	assign bus.done = (state == WRITE) && (cnt == CYCLE_LAST);
	assign lcd_ready = (state == IDLE) || (state == WRITE);

	always_comb begin
		lcd_e = 1'b0;
		{lcd_rs, lcd_rw, lcd_data} = '0;
		case (state)
			INIT: begin
				lcd_e = (cnt < INIT_E_CYC);
				lcd_data = init_data; // held through the wait as well
			end
			IDLE: begin
				if (bus.req) begin
					{lcd_rs, lcd_rw, lcd_data} = bus.word; // setup from accept cycle
				end
			end
			WRITE: begin
				lcd_e = (cnt >= E_START) && (cnt < E_END);
				{lcd_rs, lcd_rw, lcd_data} = word_q;
			end
			default: ;
		endcase
	end

	idle_holds: assert property (@(posedge clk) disable iff (reset)
		(state == IDLE) && !bus.req |=> (state == IDLE));

	no_e_when_quiet: assert property (@(posedge clk) disable iff (reset)
		(state == POWERUP) || (state == IDLE) |-> !lcd_e);

	accept_after_ready: assert property (@(posedge clk) disable iff (reset)
		bus.accept |-> lcd_ready);

endmodule

// File: lcd_bus_arbiter.sv
module lcd_bus_arbiter (
	input logic             clk,
	input logic             reset,
	lcd_req_if.arbiter_side cmd,
	lcd_req_if.arbiter_side text,
	lcd_req_if.requester    drv
);
	logic lock;      // a write is in flight
	logic last_text; // side granted last and owner of the write in flight
	logic pick_text; // winner among current requests
	logic sel_text;

	// on a tie the side not granted last wins
	always_comb begin
		if (cmd.req && text.req) begin
			pick_text = !last_text;
		end else begin
			pick_text = text.req;
		end
	end

	assign sel_text = lock ? last_text : pick_text;

	assign drv.req = !lock && (cmd.req || text.req);
	assign drv.word = sel_text ? text.word : cmd.word;

	assign cmd.accept = drv.accept && !sel_text;
	assign text.accept = drv.accept && sel_text;
	assign cmd.done = drv.done && !sel_text;
	assign text.done = drv.done && sel_text;

	always_ff @(posedge clk) begin
		if (reset) begin
			lock <= 1'b0;
			last_text <= 1'b1; // first tie goes to the command port
		end else if (drv.accept) begin
			lock <= 1'b1;
			last_text <= pick_text;
		end else if (drv.done) begin
			lock <= 1'b0;
		end
	end

	one_accept: assert property (@(posedge clk) disable iff (reset)
		!(cmd.accept && text.accept));

endmodule

// File: lcd_cmd_port.sv
module lcd_cmd_port (
	input  logic         clk,
	input  logic         reset,
	input  logic         cmd_valid,
	input  logic         cmd_rs,
	input  logic         cmd_rw,
	input  logic [7:0]   cmd_data,
	output logic         cmd_busy,
	lcd_req_if.requester bus
);
	import lcd_cmd_pkg::*;

	lcd_word_t word_q; // held host command
	logic      req_q;

	assign bus.req = req_q;
	assign bus.word = word_q;

	always_ff @(posedge clk) begin
		if (reset) begin
			cmd_busy <= 1'b0;
			req_q <= 1'b0;
		end else if (!cmd_busy) begin
			if (cmd_valid) begin
				cmd_busy <= 1'b1;
				req_q <= 1'b1;
			end
		end else begin
			if (bus.accept) begin
				req_q <= 1'b0;
			end
			if (bus.done) begin
				cmd_busy <= 1'b0; // ready for the next strobe
			end
		end
	end

	always_ff @(posedge clk) begin
		if (cmd_valid && !cmd_busy) begin
			word_q <= '{rs: cmd_rs, rw: cmd_rw, data: cmd_data};
		end
	end

endmodule

// File: lcd_text_writer.sv
`include "lcd_defines.svh"

module lcd_text_writer (
	input  logic                    clk,
	input  logic                    reset,
	input  logic                    text_we,
	input  lcd_text_pkg::lcd_col_t  text_col,
	input  lcd_text_pkg::lcd_char_t text_char,
	input  logic                    text_refresh,
	input  lcd_text_pkg::lcd_line_t text_line,
	output logic                    text_busy,
	lcd_req_if.requester            bus
);
	import lcd_cmd_pkg::*;
	import lcd_text_pkg::*;

	localparam lcd_col_t LAST_COL = lcd_col_t'(`LCD_LINE_LEN - 1);

	lcd_char_t  line_buf [`LCD_LINE_LEN];
	lcd_line_t  line_q;     // line being refreshed
	lcd_col_t   col;        // next character to send
	logic       addr_phase; // set-address word still pending
	logic       req_q;
	logic [7:0] line_base;

	assign line_base = line_q ? LINE1_BASE : 8'h00;

	assign bus.req = req_q;
	assign bus.word = addr_phase
		? lcd_word_t'{rs: 1'b0, rw: 1'b0, data: OP_SET_DDRAM | line_base}
		: lcd_word_t'{rs: 1'b1, rw: 1'b0, data: line_buf[col]};

	// host side of the buffer, open at any time
	always_ff @(posedge clk) begin
		if (reset) begin
			for (int i = 0; i < `LCD_LINE_LEN; i++) begin
				line_buf[i] <= CHAR_SPACE;
			end
		end else if (text_we) begin
			line_buf[text_col] <= text_char;
		end
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			text_busy <= 1'b0;
			req_q <= 1'b0;
			addr_phase <= 1'b0;
			col <= '0;
			line_q <= 1'b0;
		end else if (!text_busy) begin
			if (text_refresh) begin
				text_busy <= 1'b1;
				req_q <= 1'b1;
				addr_phase <= 1'b1;
				col <= '0;
				line_q <= text_line;
			end
		end else begin
			if (bus.accept) begin
				req_q <= 1'b0;
			end
			if (bus.done) begin
				if (addr_phase) begin
					addr_phase <= 1'b0; // column 0 next
					req_q <= 1'b1;
				end else if (col == LAST_COL) begin
					text_busy <= 1'b0;
				end else begin
					col <= col + 4'd1;
					req_q <= 1'b1;
				end
			end
		end
	end

	no_req_idle: assert property (@(posedge clk) disable iff (reset)
		!text_busy |-> !bus.req);

endmodule

// File: lcd_subsystem.sv
module lcd_subsystem (
	input  logic                    clk,
	input  logic                    reset,
	input  lcd_cmd_pkg::lcd_cfg_t   cfg,
	input  logic                    cmd_valid,
	input  logic                    cmd_rs,
	input  logic                    cmd_rw,
	input  logic [7:0]              cmd_data,
	output logic                    cmd_busy,
	input  logic                    text_we,
	input  lcd_text_pkg::lcd_col_t  text_col,
	input  lcd_text_pkg::lcd_char_t text_char,
	input  logic                    text_refresh,
	input  lcd_text_pkg::lcd_line_t text_line,
	output logic                    text_busy,
	output logic                    lcd_e,
	output logic                    lcd_rs,
	output logic                    lcd_rw,
	output logic [7:0]              lcd_data,
	output logic                    lcd_ready
);
	lcd_req_if cmd_req ();
	lcd_req_if text_req ();
	lcd_req_if drv_req ();

	lcd_cmd_port u_cmd_port (
		.clk       (clk),
		.reset     (reset),
		.cmd_valid (cmd_valid),
		.cmd_rs    (cmd_rs),
		.cmd_rw    (cmd_rw),
		.cmd_data  (cmd_data),
		.cmd_busy  (cmd_busy),
		.bus       (cmd_req.requester)
	);

	lcd_text_writer u_text_writer (
		.clk          (clk),
		.reset        (reset),
		.text_we      (text_we),
		.text_col     (text_col),
		.text_char    (text_char),
		.text_refresh (text_refresh),
		.text_line    (text_line),
		.text_busy    (text_busy),
		.bus          (text_req.requester)
	);

	lcd_bus_arbiter u_arbiter (
		.clk   (clk),
		.reset (reset),
		.cmd   (cmd_req.arbiter_side),
		.text  (text_req.arbiter_side),
		.drv   (drv_req.requester)
	);

	lcd_bus_driver u_driver (
		.clk       (clk),
		.reset     (reset),
		.cfg       (cfg),
		.bus       (drv_req.driver),
		.lcd_e     (lcd_e),
		.lcd_rs    (lcd_rs),
		.lcd_rw    (lcd_rw),
		.lcd_data  (lcd_data),
		.lcd_ready (lcd_ready)
	);

endmodule

// File: tb_lcd_subsystem.sv
`include "lcd_defines.svh"

module tb_lcd_subsystem;
	import lcd_cmd_pkg::*;
	import lcd_text_pkg::*;

	localparam int E_WIDTH = (`LCD_E_END_US - `LCD_E_START_US) * `LCD_CLK_PER_US;
	localparam int CYCLE_LEN = `LCD_CYCLE_US * `LCD_CLK_PER_US;

	logic      clk;
	logic      reset;
	lcd_cfg_t  cfg;
	logic      cmd_valid;
	logic      cmd_rs;
	logic      cmd_rw;
	logic [7:0] cmd_data;
	logic      cmd_busy;
	logic      text_we;
	lcd_col_t  text_col;
	lcd_char_t text_char;
	logic      text_refresh;
	lcd_line_t text_line;
	logic      text_busy;
	logic      lcd_e;
	logic      lcd_rs;
	logic      lcd_rw;
	logic [7:0] lcd_data;
	logic      lcd_ready;

	lcd_word_t   words[$]; // bus word at each rising lcd_e
	int          rises[$];
	int          falls[$];
	int          cyc = 0;
	bit          e_prev = 1'b0;
	int          word_errors = 0;
	int          count_errors = 0;
	int          other_errors = 0;
	int          rel_cyc;  // cycle count when reset dropped
	lcd_char_t   chars [`LCD_LINE_LEN];

	lcd_subsystem UUT (.*);

	initial begin
		clk = 1'b0;
		forever #50 clk = ~clk;
	end

	// pin monitor
	always @(posedge clk) begin
		cyc = cyc + 1;
		if (lcd_e === 1'b1 && !e_prev) begin
			words.push_back(lcd_word_t'({lcd_rs, lcd_rw, lcd_data}));
			rises.push_back(cyc);
		end
		if (lcd_e === 1'b0 && e_prev) begin
			falls.push_back(cyc);
		end
		e_prev = (lcd_e === 1'b1);
	end

	task automatic finish_run();
		$display("errors: %0d word, %0d count, %0d other", word_errors, count_errors,
			other_errors);
		if (word_errors + count_errors + other_errors == 0) begin
			$display("Finished with no errors");
		end else begin
			$display("Finished with errors");
		end
		$finish;
	endtask

	task automatic report_timeout(input string what);
		$display("Timeout: %s", what);
		other_errors++;
		finish_run();
	endtask

	task automatic check_word(input string name, input lcd_word_t exp, input lcd_word_t act);
		if (act !== exp) begin
			$display("Error %s: expected rs=%b rw=%b data=%h, actual rs=%b rw=%b data=%h",
				name, exp.rs, exp.rw, exp.data, act.rs, act.rw, act.data);
			word_errors++;
		end
	endtask

	task automatic check_count(input string name, input int exp, input int act,
			input bit at_least);
		if (at_least ? (act < exp) : (act != exp)) begin
			$display("Error %s: expected %s%0d, actual %0d", name, at_least ? ">= " : "",
				exp, act);
			count_errors++;
		end
	endtask

	task automatic wait_ready(input int limit);
		int n;
		n = 0;
		while (lcd_ready !== 1'b1 && n < limit) begin
			@(negedge clk);
			n++;
		end
		if (lcd_ready !== 1'b1) report_timeout("lcd_ready never rose after init");
	endtask

	task automatic wait_idle(input int limit);
		int n;
		n = 0;
		while ((cmd_busy !== 1'b0 || text_busy !== 1'b0) && n < limit) begin
			@(negedge clk);
			n++;
		end
		if (cmd_busy !== 1'b0 || text_busy !== 1'b0) report_timeout("ports stayed busy");
	endtask

	// HD44780 instruction encodings built from cfg
	function automatic lcd_word_t expected_init_word(input int idx, input lcd_cfg_t c);
		logic [7:0] d;
		case (idx)
			0: d = {3'b001, 1'b1, c.lines, c.font, 2'b00}; // function set, 8-bit bus
			1: d = {5'b00001, c.display_on, c.cursor, c.blink};
			2: d = 8'h01;
			default: d = {6'b000001, c.inc_dec, c.shift};
		endcase
		return lcd_word_t'{rs: 1'b0, rw: 1'b0, data: d};
	endfunction

	function automatic lcd_word_t random_word();
		return lcd_word_t'(10'($urandom));
	endfunction

	task automatic send_cmd(input lcd_word_t w);
		@(negedge clk);
		cmd_valid = 1'b1;
		{cmd_rs, cmd_rw, cmd_data} = w;
		@(negedge clk);
		cmd_valid = 1'b0;
	endtask

	// command strobed during power-up must wait for init
	task automatic init_sequence();
		lcd_word_t early;
		early = random_word();
		check_count("ready low after reset", 0, lcd_ready, 1'b0);
		send_cmd(early);
		wait_ready(12000);
		check_count("init words before ready", 4, words.size(), 1'b0);
		check_count("command held until ready", 1, cmd_busy, 1'b0);
		for (int i = 0; i < 4 && i < words.size(); i++) begin
			check_word($sformatf("init word %0d", i), expected_init_word(i, cfg), words[i]);
		end
		if (rises.size() > 0) begin
			check_count("power-up wait", `LCD_POWERUP_US * `LCD_CLK_PER_US,
				rises[0] - rel_cyc, 1'b1);
		end
		wait_idle(1000);
		check_count("words after init", 5, words.size(), 1'b0);
		if (words.size() > 4) check_word("early command", early, words[4]);
	endtask

	task automatic raw_command();
		lcd_word_t w;
		int n;
		w = random_word();
		words.delete();
		send_cmd(w);
		n = 0;
		while (cmd_busy === 1'b1 && n < 2 * CYCLE_LEN) begin
			n++;
			@(negedge clk);
		end
		if (cmd_busy !== 1'b0) report_timeout("cmd_busy never fell");
		check_count("cmd busy cycles", CYCLE_LEN, n, 1'b0);
		check_count("raw command words", 1, words.size(), 1'b0);
		if (words.size() > 0) check_word("raw command", w, words[0]);
	endtask

	task automatic write_and_refresh_line();
		for (int i = 0; i < `LCD_LINE_LEN; i++) begin
			chars[i] = lcd_char_t'($urandom);
			@(negedge clk);
			text_we = 1'b1;
			text_col = lcd_col_t'(i);
			text_char = chars[i];
		end
		words.delete();
		@(negedge clk);
		text_we = 1'b0;
		text_refresh = 1'b1;
		text_line = 1'b1;
		@(negedge clk);
		text_refresh = 1'b0;
		check_count("text busy after refresh", 1, text_busy, 1'b0);
		wait_idle(20 * CYCLE_LEN);
		check_count("text words", 17, words.size(), 1'b0);
		if (words.size() > 0) check_word("line 1 address", 10'h0C0, words[0]);
		for (int i = 1; i < 17 && i < words.size(); i++) begin
			check_word($sformatf("text col %0d", i - 1), {2'b10, chars[i - 1]}, words[i]);
		end
	endtask

	// tie goes to cmd and a queued cmd follows the text word in flight
	task automatic arbitration();
		lcd_word_t first;
		lcd_word_t second;
		lcd_word_t exp[$];
		first = random_word();
		second = random_word();
		words.delete();
		@(negedge clk);
		cmd_valid = 1'b1;
		{cmd_rs, cmd_rw, cmd_data} = first;
		text_refresh = 1'b1;
		text_line = 1'b0;
		@(negedge clk);
		cmd_valid = 1'b0;
		text_refresh = 1'b0;
		for (int n = 0; cmd_busy === 1'b1; n++) begin
			if (n > 2 * CYCLE_LEN) report_timeout("first command never finished");
			@(negedge clk);
		end
		send_cmd(second);
		wait_idle(22 * CYCLE_LEN);
		exp.push_back(first);
		exp.push_back(10'h080);
		exp.push_back(second);
		for (int i = 0; i < `LCD_LINE_LEN; i++) exp.push_back({2'b10, chars[i]});
		check_count("arbitration words", exp.size(), words.size(), 1'b0);
		for (int i = 0; i < exp.size() && i < words.size(); i++) begin
			check_word($sformatf("arbitration word %0d", i), exp[i], words[i]);
		end
	endtask

	// pulses 0 to 3 belong to init
	task automatic write_timing();
		check_count("edge pairs", rises.size(), falls.size(), 1'b0);
		for (int i = 4; i < rises.size() && i < falls.size(); i++) begin
			check_count($sformatf("e width %0d", i), E_WIDTH, falls[i] - rises[i], 1'b0);
			if (i > 4) begin
				check_count($sformatf("e spacing %0d", i), CYCLE_LEN,
					rises[i] - rises[i - 1], 1'b1);
			end
		end
	endtask

	initial begin
		void'($urandom(32'h5977));
		reset = 1'b1;
		cfg = 7'($urandom);
		cmd_valid = 1'b0;
		cmd_rs = 1'b0;
		cmd_rw = 1'b0;
		cmd_data = 8'h00;
		text_we = 1'b0;
		text_col = '0;
		text_char = '0;
		text_refresh = 1'b0;
		text_line = 1'b0;
		repeat (8) @(negedge clk);
		reset = 1'b0;
		rel_cyc = cyc;
		init_sequence();
		raw_command();
		write_and_refresh_line();
		arbitration();
		write_timing();
		finish_run();
	end

endmodule

// File: vlog.f
+incdir+.
lcd_cmd_pkg.sv
lcd_text_pkg.sv
lcd_req_if.sv
lcd_bus_driver.sv
lcd_bus_arbiter.sv
lcd_cmd_port.sv
lcd_text_writer.sv
lcd_subsystem.sv
tb_lcd_subsystem.sv
